// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execUnit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f tb.f --top-module execUnit_tb -Mdir obj_dir -o execUnit_sim

./obj_dir/execUnit_sim 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  aluPkg::dataT inA,
  input  aluPkg::dataT inB,
  input  aluPkg::opT   op,
  output aluPkg::dataT out,
  output logic         msb,
  output logic         zero
);

  aluPkg::dataT diff;
  aluPkg::dataT sum;
  logic         carry;
  aluPkg::dataT rolRes;
  aluPkg::dataT sllRes;
  aluPkg::dataT rorRes;
  aluPkg::dataT srlRes;
  aluPkg::dataT btrRes;
  aluPkg::dataT slbiRes;
  logic         eqBit;
  logic         ltBit;

  // Shared subtractor, B minus A
  assign diff = inB - inA;

  // Adder with carry out for OpAdd and OpSco
  assign {carry, sum} = {1'b0, inA} + {1'b0, inB};

  // One shifter per mode, count from the low nibble of B
  barrelShifter u_rol (.in(inA), .cnt(inB[3:0]), .mode(aluPkg::ShRol), .out(rolRes));
  barrelShifter u_sll (.in(inA), .cnt(inB[3:0]), .mode(aluPkg::ShSll), .out(sllRes));
  barrelShifter u_ror (.in(inA), .cnt(inB[3:0]), .mode(aluPkg::ShRor), .out(rorRes));
  barrelShifter u_srl (.in(inA), .cnt(inB[3:0]), .mode(aluPkg::ShSrl), .out(srlRes));

  assign btrRes = {<<{inA}};

  // Low byte of A moves up, B fills in
  assign slbiRes = {inA[7:0], 8'h00} | inB;

  assign eqBit = (diff == '0);

  // Difference sign is only valid when A and B share a sign
  assign ltBit = (inA[15] ^ inB[15]) ? inA[15] : (~diff[15] & ~eqBit);

  always_comb begin
    case (op)
      aluPkg::OpSub:     out = diff;
      aluPkg::OpAdd:     out = sum;
      aluPkg::OpAndn:    out = inA & ~inB;
      aluPkg::OpXor:     out = inA ^ inB;
      aluPkg::OpRol:     out = rolRes;
      aluPkg::OpSll:     out = sllRes;
      aluPkg::OpRor:     out = rorRes;
      aluPkg::OpSrl:     out = srlRes;
      aluPkg::OpBtr:     out = btrRes;
      aluPkg::OpSeq:     out = {15'd0, eqBit};
      aluPkg::OpSlt:     out = {15'd0, ltBit};
      aluPkg::OpSle:     out = {15'd0, ltBit | eqBit};
      aluPkg::OpSco:     out = {15'd0, carry};
      aluPkg::OpPass:    out = inB;
      aluPkg::OpSlbi:    out = slbiRes;
      aluPkg::OpSlbiAlt: out = slbiRes;
      default:           out = '0;
    endcase
  end

  // Flags of operand A for a later branch unit
  assign msb  = inA[15];
  assign zero = (inA == '0);

endmodule

`default_nettype wire

// ==== source/aluPkg.sv ====
`default_nettype none

package aluPkg;

  // Widths fixed by the instruction format
  typedef logic [15:0] dataT;
  typedef logic [2:0]  regAddrT;
  typedef logic [3:0]  opT;
  typedef logic [1:0]  shiftModeT;

  // op, rd, rs, immSel, rt, imm from the top bit down
  typedef logic [21:0] instrT;

  // Lowest bit of each instruction field
  localparam int OpLsb     = 18;
  localparam int RdLsb     = 15;
  localparam int RsLsb     = 12;
  localparam int ImmSelBit = 11;
  localparam int RtLsb     = 8;
  localparam int ImmLsb    = 0;

  // Shifter modes, bit 1 selects right, bit 0 selects zero fill
  localparam shiftModeT ShRol = 2'd0;
  localparam shiftModeT ShSll = 2'd1;
  localparam shiftModeT ShRor = 2'd2;
  localparam shiftModeT ShSrl = 2'd3;

  // ALU operation codes
  localparam opT OpSub     = 4'd0;
  localparam opT OpAdd     = 4'd1;
  localparam opT OpAndn    = 4'd2;
  localparam opT OpXor     = 4'd3;
  localparam opT OpRol     = 4'd4;
  localparam opT OpSll     = 4'd5;
  localparam opT OpRor     = 4'd6;
  localparam opT OpSrl     = 4'd7;
  localparam opT OpBtr     = 4'd8;
  localparam opT OpSeq     = 4'd9;
  localparam opT OpSlt     = 4'd10;
  localparam opT OpSle     = 4'd11;
  localparam opT OpSco     = 4'd12;
  localparam opT OpPass    = 4'd13;
  localparam opT OpSlbi    = 4'd14;
  localparam opT OpSlbiAlt = 4'd15;

endpackage

`default_nettype wire

// ==== source/barrelShifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module barrelShifter (
  input  aluPkg::dataT      in,
  input  logic [3:0]        cnt,
  input  aluPkg::shiftModeT mode,
  output aluPkg::dataT      out
);

  aluPkg::dataT stage [5];
  aluPkg::dataT inRev;
  aluPkg::dataT outRev;
  logic         mirror;
  logic         fillZero;

  assign mirror   = mode[1];
  assign fillZero = mode[0];

  // Right shifts run through the left shifter on a mirrored word
  assign inRev = {<<{in}};

  // Levels of 1, 2, 4 and 8 places
  always_comb begin
    stage[0] = mirror ? inRev : in;
    for (int lvl = 0; lvl < 4; lvl++) begin
      if (!cnt[lvl]) begin
        stage[lvl+1] = stage[lvl];
      end else if (fillZero) begin
        stage[lvl+1] = stage[lvl] << (1 << lvl);
      end else begin
        // Bits leaving the top wrap around
        stage[lvl+1] = (stage[lvl] << (1 << lvl)) | (stage[lvl] >> (16 - (1 << lvl)));
      end
    end
  end

  assign outRev = {<<{stage[4]}};
  assign out    = mirror ? outRev : stage[4];

endmodule

`default_nettype wire

// ==== source/execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execUnit (
  input  logic            clk,
  input  logic            reset,
  input  logic            instrValid,
  input  aluPkg::instrT   instr,
  output logic            instrReady,
  output logic            resValid,
  input  logic            resReady,
  output aluPkg::dataT    resData,
  output aluPkg::regAddrT resDest,
  output logic            resMsb,
  output logic            resZero
);

  aluPkg::regAddrT rsAddr;
  aluPkg::regAddrT rtAddr;
  aluPkg::dataT    rsData;
  aluPkg::dataT    rtData;
  logic            slotValid;
  logic            slotReady;
  aluPkg::opT      slotOp;
  aluPkg::regAddrT slotDest;
  aluPkg::dataT    slotA;
  aluPkg::dataT    slotB;
  aluPkg::dataT    aluOut;
  logic            aluMsb;
  logic            aluZero;
  logic            pendValid;
  aluPkg::regAddrT pendDest;
  logic            wrEn;
  aluPkg::regAddrT wrAddr;
  aluPkg::dataT    wrData;

  instrDecode u_instrDecode (
    .clk(clk), .reset(reset),
    .instrValid(instrValid), .instr(instr), .instrReady(instrReady),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
    .pendValid(pendValid), .pendDest(pendDest),
    .slotValid(slotValid), .slotReady(slotReady), .slotOp(slotOp),
    .slotDest(slotDest), .slotA(slotA), .slotB(slotB)
  );

  regFile u_regFile (
    .clk(clk), .reset(reset),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

  // Execute straight from the decoded slot
  alu u_alu (
    .inA(slotA), .inB(slotB), .op(slotOp),
    .out(aluOut), .msb(aluMsb), .zero(aluZero)
  );

  resultStage u_resultStage (
    .clk(clk), .reset(reset),
    .slotValid(slotValid), .slotReady(slotReady), .slotDest(slotDest),
    .aluOut(aluOut), .aluMsb(aluMsb), .aluZero(aluZero),
    .resValid(resValid), .resReady(resReady), .resData(resData),
    .resDest(resDest), .resMsb(resMsb), .resZero(resZero),
    .pendValid(pendValid), .pendDest(pendDest),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

endmodule

`default_nettype wire

// ==== source/instrDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
  input  logic            clk,
  input  logic            reset,
  input  logic            instrValid,
  input  aluPkg::instrT   instr,
  output logic            instrReady,
  output aluPkg::regAddrT rsAddr,
  output aluPkg::regAddrT rtAddr,
  input  aluPkg::dataT    rsData,
  input  aluPkg::dataT    rtData,
  input  logic            pendValid,
  input  aluPkg::regAddrT pendDest,
  output logic            slotValid,
  input  logic            slotReady,
  output aluPkg::opT      slotOp,
  output aluPkg::regAddrT slotDest,
  output aluPkg::dataT    slotA,
  output aluPkg::dataT    slotB
);

  aluPkg::opT      op;
  aluPkg::regAddrT rd;
  logic            immSel;
  logic [7:0]      imm;
  logic            rsHazard;
  logic            rtHazard;
  logic            slotFree;
  logic            readyEn;
  logic            accept;

  // Instruction fields
  assign op     = instr[aluPkg::OpLsb +: 4];
  assign rd     = instr[aluPkg::RdLsb +: 3];
  assign rsAddr = instr[aluPkg::RsLsb +: 3];
  assign immSel = instr[aluPkg::ImmSelBit];
  assign rtAddr = instr[aluPkg::RtLsb +: 3];
  assign imm    = instr[aluPkg::ImmLsb +: 8];

  // Source registers still owed a write by the slot or the result stage
  assign rsHazard = (slotValid && rsAddr == slotDest) || (pendValid && rsAddr == pendDest);
  assign rtHazard = !immSel &&
                    ((slotValid && rtAddr == slotDest) || (pendValid && rtAddr == pendDest));

  // Slot empty or leaving on this edge
  assign slotFree = !slotValid || slotReady;

  assign instrReady = readyEn && slotFree && !rsHazard && !rtHazard;
  assign accept     = instrValid && instrReady;

  // Opens the input one cycle after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      readyEn   <= 1'b0;
      slotValid <= 1'b0;
    end else begin
      readyEn <= 1'b1;
      if (accept) begin
        slotValid <= 1'b1;
      end else if (slotReady) begin
        slotValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      slotOp   <= op;
      slotDest <= rd;
      slotA    <= rsData;
      slotB    <= immSel ? {8'h00, imm} : rtData;
    end
  end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  logic            clk,
  input  logic            reset,
  input  aluPkg::regAddrT rsAddr,
  input  aluPkg::regAddrT rtAddr,
  output aluPkg::dataT    rsData,
  output aluPkg::dataT    rtData,
  input  logic            wrEn,
  input  aluPkg::regAddrT wrAddr,
  input  aluPkg::dataT    wrData
);

  aluPkg::dataT regs [8];

  // Write lands on the edge, no bypass to the read ports
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Combinational reads
  assign rsData = regs[rsAddr];
  assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

// ==== source/resultStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module resultStage (
  input  logic            clk,
  input  logic            reset,
  input  logic            slotValid,
  output logic            slotReady,
  input  aluPkg::regAddrT slotDest,
  input  aluPkg::dataT    aluOut,
  input  logic            aluMsb,
  input  logic            aluZero,
  output logic            resValid,
  input  logic            resReady,
  output aluPkg::dataT    resData,
  output aluPkg::regAddrT resDest,
  output logic            resMsb,
  output logic            resZero,
  output logic            pendValid,
  output aluPkg::regAddrT pendDest,
  output logic            wrEn,
  output aluPkg::regAddrT wrAddr,
  output aluPkg::dataT    wrData
);

  logic take;
  logic done;

  // Room when empty or when the held result leaves now
  assign slotReady = !resValid || resReady;
  assign take      = slotValid && slotReady;
  assign done      = resValid && resReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      resValid <= 1'b0;
    end else if (take) begin
      resValid <= 1'b1;
    end else if (done) begin
      resValid <= 1'b0;
    end
  end

  // Result and flags of operand A
  always_ff @(posedge clk) begin
    if (take) begin
      resData <= aluOut;
      resDest <= slotDest;
      resMsb  <= aluMsb;
      resZero <= aluZero;
    end
  end

  // Write-back rides on the result handshake
  assign wrEn   = done;
  assign wrAddr = resDest;
  assign wrData = resData;

  // Waiting write seen by the interlock
  assign pendValid = resValid;
  assign pendDest  = resDest;

endmodule

`default_nettype wire

// ==== tb.f ====
source/aluPkg.sv
source/barrelShifter.sv
source/alu.sv
source/regFile.sv
source/instrDecode.sv
source/resultStage.sv
source/execUnit.sv
verification/clockGen.sv
verification/execUnit_checker.sv
verification/execUnit_tb.sv

// ==== verification/alu_cases.txt ====
// Each line holds instr resData resDest resMsb resZero in hex
// Registers r1 to r5 are loaded first and read by the later cases
348812 0012 1 0 1  // OpPass r1 imm 12
389834 1234 1 0 0  // OpSlbi r1
350880 0080 2 0 1  // OpPass r2 imm 80
392800 8000 2 0 0  // OpSlbi r2
35887F 007F 3 0 1  // OpPass r3 imm 7F
3DB8FF 7FFF 3 0 0  // OpSlbiAlt r3
3608FF 00FF 4 0 1  // OpPass r4 imm FF
3A48FE FFFE 4 0 0  // OpSlbi r4
3688A5 00A5 5 0 1  // OpPass r5 imm A5
3AD85A A55A 5 0 0  // OpSlbi r5
031500 9326 6 0 0  // OpSub r5 - r1
071300 9233 6 0 0  // OpAdd r1 + r3
0B5400 0000 6 1 0  // OpAndn r5 r4
0F5100 B76E 6 1 0  // OpXor r5 r1
334300 0001 6 1 0  // OpSco with carry
331300 0000 6 0 0  // OpSco without carry
032801 8001 6 1 0  // OpSub imm 1 - r2
13D200 A55A 7 1 0  // OpRol by r2 (0)
13D801 4AB5 7 1 0  // OpRol imm 1
13D808 5AA5 7 1 0  // OpRol imm 8
13D300 52AD 7 1 0  // OpRol by r3 (15)
17D800 A55A 7 1 0  // OpSll imm 0
17D801 4AB4 7 1 0  // OpSll imm 1
17D808 5A00 7 1 0  // OpSll imm 8
17D80F 0000 7 1 0  // OpSll imm 15
1BD200 A55A 7 1 0  // OpRor by r2 (0)
1BD801 52AD 7 1 0  // OpRor imm 1
1BD808 5AA5 7 1 0  // OpRor imm 8
1BD80F 4AB5 7 1 0  // OpRor imm 15
1FD800 A55A 7 1 0  // OpSrl imm 0
1FD801 52AD 7 1 0  // OpSrl imm 1
1FD808 00A5 7 1 0  // OpSrl imm 8
1FD300 0001 7 1 0  // OpSrl by r3 (15)
239800 2C48 7 0 0  // OpBtr r1
23D700 5AA5 7 1 0  // OpBtr r5, rt r7 still in flight
271100 0001 6 0 0  // OpSeq r1 r1
271300 0000 6 0 0  // OpSeq r1 r3
2B2300 0001 6 1 0  // OpSlt 8000 7FFF
2B3200 0000 6 0 0  // OpSlt 7FFF 8000
2B4500 0000 6 1 0  // OpSlt FFFE A55A
2B5400 0001 6 1 0  // OpSlt A55A FFFE
2B1300 0001 6 0 0  // OpSlt 1234 7FFF
2F1100 0001 6 0 0  // OpSle r1 r1
2F0400 0000 6 0 1  // OpSle 0 FFFE
079801 1235 7 0 0  // OpAdd r7 = r1 + 1
07F700 246A 7 0 0  // OpAdd r7 = r7 + r7
0F7100 365E 6 0 0  // OpXor r6 = r7 ^ r1
037600 11F4 6 0 0  // OpSub r6 = r6 - r7
348600 11F4 1 0 1  // OpPass r1 = r6
111804 1F41 2 0 0  // OpRol r2 = r1 by 4

// ==== verification/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic reset
);

  localparam int ResetCycles = 10;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Released just after the tenth rising edge
  initial begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verification/execUnit_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module execUnit_checker (
  input logic            clk,
  input logic            reset,
  input logic            instrReady,
  input logic            resValid,
  input logic            resReady,
  input aluPkg::dataT    resData,
  input aluPkg::regAddrT resDest,
  input logic            resMsb,
  input logic            resZero
);

  // No result while in reset or in the first cycle out of it
  resIdleAfterReset: assert property (@(posedge clk) $past(reset) |-> !resValid)
    else $error("resValid high during or right after reset");

  // A stalled result keeps every output
  resHold: assert property (@(posedge clk) disable iff (reset)
    (resValid && !resReady) |=> (resValid && $stable(resData) && $stable(resDest)
      && $stable(resMsb) && $stable(resZero)))
    else $error("Result outputs changed while resReady was low");

  // Input stream stays closed in reset
  readyLowInReset: assert property (@(posedge clk) $past(reset) |-> !instrReady)
    else $error("instrReady high during reset");

endmodule

`default_nettype wire

// ==== verification/execUnit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module execUnit_tb;

  localparam string CasesFile = "verification/alu_cases.txt";
  localparam int    Seed      = 67624;

  logic            clk;
  logic            reset;
  logic            instrValid;
  aluPkg::instrT   instr;
  logic            instrReady;
  logic            resValid;
  logic            resReady;
  aluPkg::dataT    resData;
  aluPkg::regAddrT resDest;
  logic            resMsb;
  logic            resZero;

  aluPkg::instrT   instrQ [$];
  aluPkg::dataT    expData [$];
  aluPkg::regAddrT expDest [$];
  logic            expMsb [$];
  logic            expZero [$];

  int numCases;
  int received;
  int mismatches;
  int failures;
  int cycles;
  int cycleLimit;

  clockGen u_clockGen (.clk(clk), .reset(reset));

  execUnit u_execUnit (
    .clk(clk), .reset(reset),
    .instrValid(instrValid), .instr(instr), .instrReady(instrReady),
    .resValid(resValid), .resReady(resReady), .resData(resData),
    .resDest(resDest), .resMsb(resMsb), .resZero(resZero)
  );

  bind execUnit execUnit_checker u_execUnitChecker (
    .clk(clk), .reset(reset), .instrReady(instrReady), .resValid(resValid),
    .resReady(resReady), .resData(resData), .resDest(resDest),
    .resMsb(resMsb), .resZero(resZero)
  );

  task automatic compare(input string name, input logic [15:0] actual,
                         input logic [15:0] expected);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic loadCases();
    int          fd;
    string       line;
    logic [21:0] fInstr;
    logic [15:0] fData;
    logic [2:0]  fDest;
    logic        fMsb;
    logic        fZero;
    fd = $fopen(CasesFile, "r");
    if (fd == 0) begin
      failures++;
      $display("Could not open the cases file %s", CasesFile);
      return;
    end
    // Comment and blank lines give fewer than five fields
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%h %h %h %h %h", fInstr, fData, fDest, fMsb, fZero) == 5) begin
        instrQ.push_back(fInstr);
        expData.push_back(fData);
        expDest.push_back(fDest);
        expMsb.push_back(fMsb);
        expZero.push_back(fZero);
      end
    end
    $fclose(fd);
    numCases = instrQ.size();
  endtask

  // Called at posedge + 1 and returns there after each transfer
  task automatic sendInstrs();
    int gap;
    foreach (instrQ[i]) begin
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      instrValid = 1'b1;
      instr      = instrQ[i];
      do begin
        @(negedge clk);
      end while (!instrReady);
      @(posedge clk);
      #1;
      instrValid = 1'b0;
    end
  endtask

  // Handshake decided at the falling edge where outputs are settled
  task automatic takeResults();
    while (received < numCases) begin
      @(posedge clk);
      #1;
      resReady = ($urandom_range(0, 2) != 0);
      @(negedge clk);
      if (resValid && resReady) begin
        compare("resData", resData, expData[received]);
        compare("resDest", 16'(resDest), 16'(expDest[received]));
        compare("resMsb", 16'(resMsb), 16'(expMsb[received]));
        compare("resZero", 16'(resZero), 16'(expZero[received]));
        received++;
      end
    end
  endtask

  initial begin
    instrValid = 1'b0;
    instr      = '0;
    resReady   = 1'b0;
    void'($urandom(Seed));
    loadCases();
    if (numCases == 0) begin
      failures++;
      $display("No cases were read");
    end
    cycleLimit = 40 * numCases + 200;
    @(posedge clk);
    while (reset) @(posedge clk);
    #1;
    fork
      sendInstrs();
      takeResults();
    join
    // Nothing else may come out once every case is back
    @(posedge clk);
    #1;
    resReady = 1'b1;
    repeat (10) begin
      @(negedge clk);
      if (resValid) begin
        failures++;
        $display("Unexpected extra result at %0t with resData %h", $time, resData);
      end
    end
    $display("Results %0d of %0d, mismatches %0d, failures %0d",
             received, numCases, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycles = 0;
    wait (cycleLimit > 0);
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    failures++;
    $display("Timeout after %0d cycles with %0d of %0d results received",
             cycles, received, numCases);
    $display("Results %0d of %0d, mismatches %0d, failures %0d",
             received, numCases, mismatches, failures);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
